// File: source/aluPkg.sv
package aluPkg;

	// Datapath sizes fixed by the instruction format
	localparam int dataWidth = 16; // One machine word
	localparam int opWidth = 8; // Full opcode field
	localparam int flagCount = 5; // C, F, L, Z, N

	// Bit positions inside the flag word
	localparam int flagC = 0; // Carry out or borrow
	localparam int flagF = 1; // Signed overflow
	localparam int flagL = 2; // Unsigned less than
	localparam int flagZ = 3; // Operands equal
	localparam int flagN = 4; // Signed less than

	// Register forms
	// Upper nibble zero, function code in the low nibble
	localparam logic [opWidth-1:0] opAnd = 8'b0000_0001;
	localparam logic [opWidth-1:0] opOr = 8'b0000_0010;
	localparam logic [opWidth-1:0] opXor = 8'b0000_0011;
	localparam logic [opWidth-1:0] opAddcu = 8'b0000_0100; // Adds stored carry
	localparam logic [opWidth-1:0] opAdd = 8'b0000_0101;
	localparam logic [opWidth-1:0] opAddu = 8'b0000_0110;
	localparam logic [opWidth-1:0] opSub = 8'b0000_1001;
	localparam logic [opWidth-1:0] opCmp = 8'b0000_1011;
	localparam logic [opWidth-1:0] opMov = 8'b0000_1101;
	localparam logic [opWidth-1:0] opNot = 8'b0000_1111;

	// Shift group lives under upper nibble 1000
	localparam logic [opWidth-1:0] opLsh = 8'b1000_0100; // Logical left
	localparam logic [opWidth-1:0] opRsh = 8'b1000_0101; // Logical right
	localparam logic [opWidth-1:0] opArsh = 8'b1000_0111; // Arithmetic right

	// Immediate forms
	// Low nibble belongs to the immediate and is a wildcard in casez
	localparam logic [opWidth-1:0] opAndi = 8'b0001_????;
	localparam logic [opWidth-1:0] opOri = 8'b0010_????;
	localparam logic [opWidth-1:0] opXori = 8'b0011_????;
	localparam logic [opWidth-1:0] opAddi = 8'b0101_????;
	localparam logic [opWidth-1:0] opAddui = 8'b0110_????;
	localparam logic [opWidth-1:0] opSubi = 8'b1001_????;
	localparam logic [opWidth-1:0] opCmpi = 8'b1011_????;
	localparam logic [opWidth-1:0] opMovi = 8'b1101_????;
	localparam logic [opWidth-1:0] opLui = 8'b1111_????; // Loads upper byte

endpackage

// File: source/arithLogicUnit.sv
module arithLogicUnit (
	input logic [aluPkg::opWidth-1:0] op,
	input logic [aluPkg::dataWidth-1:0] srcA,
	input logic [aluPkg::dataWidth-1:0] srcB, // Second register or extended immediate
	input logic carryIn, // Stored C flag
	output logic aluHit, // Opcode belongs here
	output logic [aluPkg::dataWidth-1:0] aluValue,
	output logic [aluPkg::flagCount-1:0] aluFlags, // Candidate flags
	output logic [aluPkg::flagCount-1:0] aluFlagMask, // Flags this opcode writes
	output logic aluWrite
);

	import aluPkg::*;

	// Opcode classes
	logic addMode; // ADD, ADDU, ADDCU and immediates
	logic subMode; // SUB and SUBI
	logic cmpMode; // CMP and CMPI
	logic useCarry; // ADDCU only
	logic [dataWidth-1:0] logicValue; // Logic, move and LUI result

	// Shared adder
	logic invertB;
	logic [dataWidth-1:0] addB;
	logic [dataWidth:0] addCin;
	logic [dataWidth:0] sum; // Top bit is carry out

	// Flag terms
	logic overflow;
	logic isZero;
	logic srcALessSigned;
	logic lessU;
	logic lessS;

	// Decode, including the wildcard immediate patterns
	always_comb
	begin
		aluHit = 1'b1;
		addMode = 1'b0;
		subMode = 1'b0;
		cmpMode = 1'b0;
		useCarry = 1'b0;
		logicValue = '0; // Also the value seen for compares
		casez (op)
			opAnd, opAndi: logicValue = srcA & srcB;
			opOr, opOri: logicValue = srcA | srcB;
			opXor, opXori: logicValue = srcA ^ srcB;
			opNot: logicValue = ~srcA;
			opMov, opMovi: logicValue = srcB; // Plain copy
			opLui: logicValue = {srcB[7:0], 8'h00}; // Immediate byte to the top
			opAdd, opAddi, opAddu, opAddui: addMode = 1'b1;
			opAddcu:
			begin
				addMode = 1'b1;
				useCarry = 1'b1;
			end
			opSub, opSubi: subMode = 1'b1;
			opCmp, opCmpi: cmpMode = 1'b1;
			default: aluHit = 1'b0; // Shifts and unused codes
		endcase
	end

	// Subtract and compare both run srcA + ~srcB + 1
	assign invertB = subMode | cmpMode;
	assign addB = invertB ? ~srcB : srcB;
	assign addCin = {{dataWidth{1'b0}}, invertB | (useCarry & carryIn)};
	assign sum = {1'b0, srcA} + {1'b0, addB} + addCin;

	// Operand signs agree but result sign differs
	assign overflow = (srcA[dataWidth-1] == addB[dataWidth-1]) &&
		(sum[dataWidth-1] != srcA[dataWidth-1]);
	assign isZero = (sum[dataWidth-1:0] == '0); // Difference zero means equal

	// srcB below srcA: no borrow and not equal
	assign lessU = sum[dataWidth] & ~isZero;
	assign srcALessSigned = sum[dataWidth-1] ^ overflow; // Sign of true difference
	assign lessS = ~srcALessSigned & ~isZero;

	always_comb
	begin
		aluValue = (addMode | subMode) ? sum[dataWidth-1:0] : logicValue;
		aluFlags = '0;
		aluFlags[flagC] = subMode ? ~sum[dataWidth] : sum[dataWidth]; // Borrow is inverted carry
		aluFlags[flagF] = overflow;
		aluFlags[flagL] = lessU;
		aluFlags[flagZ] = isZero;
		aluFlags[flagN] = lessS;

		// Add and sub touch C and F, compares touch L, Z and N
		aluFlagMask = '0;
		aluFlagMask[flagC] = addMode | subMode;
		aluFlagMask[flagF] = addMode | subMode;
		aluFlagMask[flagL] = cmpMode;
		aluFlagMask[flagZ] = cmpMode;
		aluFlagMask[flagN] = cmpMode;

		aluWrite = aluHit & ~cmpMode; // Compares have no destination
	end

endmodule

// File: source/shiftUnit.sv
module shiftUnit (
	input logic [aluPkg::opWidth-1:0] op,
	input logic [aluPkg::dataWidth-1:0] srcA, // Value to shift
	input logic [aluPkg::dataWidth-1:0] srcB, // Amount in the low nibble
	output logic shiftHit,
	output logic [aluPkg::dataWidth-1:0] shiftValue
);

	import aluPkg::*;

	logic [3:0] amount;
	logic isLeft;
	logic fillBit; // Zero or sign for right shifts
	logic [2*dataWidth-1:0] rightWide; // Fill bits above the operand
	logic [2*dataWidth-1:0] rightShifted;
	logic [dataWidth-1:0] leftShifted;

	assign amount = srcB[3:0];

	// Claim the three shift codes
	always_comb
	begin
		shiftHit = 1'b1;
		isLeft = 1'b0;
		fillBit = 1'b0;
		case (op)
			opLsh: isLeft = 1'b1;
			opRsh: fillBit = 1'b0; // Zero fill
			opArsh: fillBit = srcA[dataWidth-1]; // Sign fill
			default: shiftHit = 1'b0;
		endcase
	end

	// One right shifter serves both right forms
	assign rightWide = {{dataWidth{fillBit}}, srcA};
	assign rightShifted = rightWide >> amount;
	assign leftShifted = srcA << amount;

	always_comb
	begin
		if (!shiftHit)
		begin
			shiftValue = '0;
		end
		else if (isLeft)
		begin
			shiftValue = leftShifted;
		end
		else
		begin
			shiftValue = rightShifted[dataWidth-1:0]; // Low word only
		end
	end

endmodule

// File: source/resultMerge.sv
module resultMerge (
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input logic aluHit,
	input logic [aluPkg::dataWidth-1:0] aluValue,
	input logic [aluPkg::flagCount-1:0] aluFlags,
	input logic [aluPkg::flagCount-1:0] aluFlagMask,
	input logic aluWrite,
	input logic shiftHit,
	input logic [aluPkg::dataWidth-1:0] shiftValue,
	output logic carryIn, // Stored C back to the adder
	output logic outValid,
	input logic outReady,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic writeEn,
	output logic [aluPkg::flagCount-1:0] flags // Flag register
);

	import aluPkg::*;

	logic accept; // Input transfer this edge
	logic [dataWidth-1:0] nextValue;
	logic nextWrite;
	logic [flagCount-1:0] nextFlags;

	// Single slot, free when empty or draining now
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	assign carryIn = flags[flagC];

	// Pick the unit that claimed the opcode
	always_comb
	begin
		if (aluHit)
		begin
			nextValue = aluValue;
			nextWrite = aluWrite;
		end
		else if (shiftHit)
		begin
			nextValue = shiftValue;
			nextWrite = 1'b1; // Shifts always write
		end
		else
		begin
			nextValue = '0; // Unknown opcode
			nextWrite = 1'b0;
		end
	end

	// Keep unmasked flags, take masked ones from the unit
	assign nextFlags = (flags & ~aluFlagMask) | (aluFlags & aluFlagMask);

	// Control state
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			flags <= '0;
		end
		else
		begin
			if (accept)
			begin
				outValid <= 1'b1;
				flags <= nextFlags; // Updated in acceptance order
			end
			else if (outReady)
			begin
				outValid <= 1'b0; // Slot drained
			end
		end
	end

	// Output payload, only loaded on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			result <= nextValue;
			writeEn <= nextWrite;
		end
	end

endmodule

// File: source/aluCore.sv
module aluCore (
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input logic [aluPkg::opWidth-1:0] op,
	input logic [aluPkg::dataWidth-1:0] srcA,
	input logic [aluPkg::dataWidth-1:0] srcB,
	output logic outValid,
	input logic outReady,
	output logic [aluPkg::dataWidth-1:0] result,
	output logic writeEn,
	output logic [aluPkg::flagCount-1:0] flags
);

	import aluPkg::*;

	// Arithmetic side
	logic aluHit;
	logic [dataWidth-1:0] aluValue;
	logic [flagCount-1:0] aluFlags;
	logic [flagCount-1:0] aluFlagMask;
	logic aluWrite;
	logic carryIn; // From the flag register

	// Shift side
	logic shiftHit;
	logic [dataWidth-1:0] shiftValue;

	// Both units see the same opcode and operands
	arithLogicUnit arithLogicUnit_inst (
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.carryIn(carryIn),
		.aluHit(aluHit),
		.aluValue(aluValue),
		.aluFlags(aluFlags),
		.aluFlagMask(aluFlagMask),
		.aluWrite(aluWrite)
	);

	shiftUnit shiftUnit_inst (
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.shiftHit(shiftHit),
		.shiftValue(shiftValue)
	);

	// Registered output and flag state
	resultMerge resultMerge_inst (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.aluHit(aluHit),
		.aluValue(aluValue),
		.aluFlags(aluFlags),
		.aluFlagMask(aluFlagMask),
		.aluWrite(aluWrite),
		.shiftHit(shiftHit),
		.shiftValue(shiftValue),
		.carryIn(carryIn),
		.outValid(outValid),
		.outReady(outReady),
		.result(result),
		.writeEn(writeEn),
		.flags(flags)
	);

endmodule

// File: tb/aluModel.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Reference behavior of the execute stage, one instruction at a time
// Flags enter as the state before the instruction and leave as the state after it
function automatic void modelExecute(
	input logic [opWidth-1:0] opCode,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic [flagCount-1:0] flagsBefore,
	output logic [dataWidth-1:0] res,
	output logic wEn,
	output logic [flagCount-1:0] flagsAfter
);
	logic [dataWidth:0] wide; // Sum with carry out on top
	logic carry;
	res = '0; // Compares and unknown codes give zero
	wEn = 1'b1;
	flagsAfter = flagsBefore;
	casez (opCode)
		opAnd, opAndi: res = a & b;
		opOr, opOri: res = a | b;
		opXor, opXori: res = a ^ b;
		opNot: res = ~a;
		opMov, opMovi: res = b;
		opLui: res = {b[7:0], 8'h00};
		opAdd, opAddi, opAddu, opAddui, opAddcu:
		begin
			carry = (opCode == opAddcu) ? flagsBefore[flagC] : 1'b0; // Only ADDCU takes C
			wide = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, carry};
			res = wide[dataWidth-1:0];
			flagsAfter[flagC] = wide[dataWidth];
			flagsAfter[flagF] = (a[dataWidth-1] == b[dataWidth-1]) &&
				(res[dataWidth-1] != a[dataWidth-1]);
		end
		opSub, opSubi:
		begin
			res = a - b;
			flagsAfter[flagC] = (a < b); // Borrow
			flagsAfter[flagF] = (a[dataWidth-1] != b[dataWidth-1]) &&
				(res[dataWidth-1] != a[dataWidth-1]);
		end
		opCmp, opCmpi:
		begin
			wEn = 1'b0; // No destination
			flagsAfter[flagL] = (b < a);
			flagsAfter[flagZ] = (a == b);
			flagsAfter[flagN] = ($signed(b) < $signed(a));
		end
		opLsh: res = a << b[3:0];
		opRsh: res = a >> b[3:0];
		opArsh: res = $signed(a) >>> b[3:0]; // Sign fill
		default: wEn = 1'b0;
	endcase
endfunction

`endif

// File: tb/aluCoreTb.sv
module aluCoreTb;

	import aluPkg::*;

	`include "aluModel.svh"

	localparam int instrCount = 2000;
	localparam int waitLimit = 100; // Cycles before a wait gives up

	// Opcode pools for the stimulus
	localparam logic [13*8-1:0] regPool = {opAnd, opOr, opXor, opNot, opAdd, opAddu, opAddcu,
		opSub, opCmp, opMov, opLsh, opRsh, opArsh};
	localparam logic [9*4-1:0] immPool = 36'h1_2356_9bdf; // Immediate upper nibbles
	localparam logic [9*8-1:0] unusedPool = 72'h00_07_08_0a_0c_0e_80_86_8f;
	localparam logic [5*4-1:0] unusedNibbles = 20'h47ace; // Free immediate groups

	logic clk;
	logic arstN;
	logic inValid;
	logic inReady;
	logic [opWidth-1:0] op;
	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] srcB;
	logic outValid;
	logic outReady;
	logic [dataWidth-1:0] result;
	logic writeEn;
	logic [flagCount-1:0] flags;

	// One accepted instruction and what it must produce
	typedef struct packed {
		logic [opWidth-1:0] op;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] res;
		logic wEn;
		logic [flagCount-1:0] flg;
	} expectEntry;

	expectEntry expectQ[$]; // Scoreboard in acceptance order
	expectEntry entry;
	logic [flagCount-1:0] modelFlags; // Model copy of the flag register
	logic [flagCount-1:0] modelNext;
	logic [dataWidth-1:0] modelRes;
	logic modelWen;
	bit inTaken; // Input went in on the coming edge
	bit timedOut;
	int sentCount;
	int checkCount;
	int mismatchCount;
	int protocolCount;
	int timeoutCount;
	int inWait; // Cycles the pending input has waited
	int outWait; // Cycles the oldest result has waited

	aluCore aluCore_inst (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.outValid(outValid),
		.outReady(outReady),
		.result(result),
		.writeEn(writeEn),
		.flags(flags)
	);

	always #50 clk = ~clk;

	// Mostly random words, corner values about a quarter of the time
	function automatic logic [dataWidth-1:0] randWord();
		logic [31:0] r;
		r = $urandom;
		if (r[31:30] != 2'b00)
		begin
			return r[15:0];
		end
		case (r[18:16])
			3'd0: return 16'h0000;
			3'd1: return 16'h0001;
			3'd2: return 16'h7fff;
			3'd3: return 16'h8000;
			3'd4: return 16'hffff;
			3'd5: return 16'h00ff;
			default: return 16'hff00;
		endcase
	endfunction

	// Legal opcodes most of the time, an unused code now and then
	function automatic logic [opWidth-1:0] randOp();
		int pick;
		logic [31:0] r;
		r = $urandom;
		pick = $urandom_range(0, 31);
		if (pick < 18)
		begin
			return regPool[(pick % 13) * 8 +: 8];
		end
		else if (pick < 29)
		begin
			return {immPool[((pick - 18) % 9) * 4 +: 4], r[3:0]}; // Random immediate nibble
		end
		else if (pick < 31)
		begin
			return unusedPool[$urandom_range(0, 8) * 8 +: 8];
		end
		return {unusedNibbles[$urandom_range(0, 4) * 4 +: 4], r[3:0]};
	endfunction

	// Compare one delivered result with the oldest expected entry
	task automatic checkOutput();
		expectEntry want;
		if (expectQ.size() != 0)
		begin
			want = expectQ.pop_front();
			checkCount++;
			assert (result === want.res)
			else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: op %h a %h b %h result %h expected %h",
					$time, want.op, want.a, want.b, result, want.res);
			end
			assert (writeEn === want.wEn)
			else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: op %h writeEn %b expected %b",
					$time, want.op, writeEn, want.wEn);
			end
			assert (flags === want.flg)
			else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: op %h a %h b %h flags %b expected %b",
					$time, want.op, want.a, want.b, flags, want.flg);
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'h4a06_5f38)); // Seeded once for a repeatable run
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		op = '0;
		srcA = '0;
		srcB = '0;
		outReady = 1'b0;
		modelFlags = '0;
		inTaken = 1'b0;
		timedOut = 1'b0;
		sentCount = 0;
		checkCount = 0;
		mismatchCount = 0;
		protocolCount = 0;
		timeoutCount = 0;
		inWait = 0;
		outWait = 0;

		repeat (10) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		#1;
		assert (!outValid && flags == '0 && inReady)
		else
		begin
			mismatchCount++;
			$display("Mismatch at %0t: after reset outValid %b flags %b inReady %b",
				$time, outValid, flags, inReady);
		end

		// One pass per falling edge, drive first and then look at the coming edge
		while ((sentCount < instrCount || inValid || expectQ.size() != 0) && !timedOut)
		begin
			@(negedge clk);
			outReady = ($urandom_range(0, 3) != 0); // Stall about a quarter of the cycles
			if (!inValid || inTaken)
			begin
				inValid = 1'b0;
				if (sentCount < instrCount && $urandom_range(0, 3) != 0) // Random gaps
				begin
					op = randOp();
					srcA = randWord();
					srcB = randWord();
					inValid = 1'b1;
					sentCount++;
				end
			end
			#1; // Let inReady settle

			// The slot is full exactly while a result is outstanding
			assert (outValid === (expectQ.size() != 0))
			else
			begin
				protocolCount++;
				$display("Mismatch at %0t: outValid %b with %0d results outstanding",
					$time, outValid, expectQ.size());
			end
			assert (inReady === (expectQ.size() == 0 || outReady)) // Free or draining now
			else
			begin
				protocolCount++;
				$display("Mismatch at %0t: inReady %b with %0d outstanding, outReady %b",
					$time, inReady, expectQ.size(), outReady);
			end

			if (outValid && outReady)
			begin
				checkOutput();
				outWait = 0;
			end
			else if (expectQ.size() != 0)
			begin
				outWait++;
			end

			inTaken = inValid && inReady;
			if (inTaken)
			begin
				modelExecute(op, srcA, srcB, modelFlags, modelRes, modelWen, modelNext);
				modelFlags = modelNext; // Flags advance in acceptance order
				entry = '{op: op, a: srcA, b: srcB, res: modelRes, wEn: modelWen, flg: modelNext};
				expectQ.push_back(entry);
				inWait = 0;
			end
			else if (inValid)
			begin
				inWait++;
			end

			if (inWait > waitLimit || outWait > waitLimit)
			begin
				timedOut = 1'b1;
				timeoutCount++;
				$display("Timeout at %0t: handshake stuck, input waited %0d, output waited %0d",
					$time, inWait, outWait);
			end
		end

		$display("Checked %0d results, %0d mismatches, %0d protocol errors, %0d timeouts",
			checkCount, mismatchCount, protocolCount, timeoutCount);
		if (mismatchCount == 0 && protocolCount == 0 && timeoutCount == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+tb
source/aluPkg.sv
source/arithLogicUnit.sv
source/shiftUnit.sv
source/resultMerge.sv
source/aluCore.sv
tb/aluCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f sim.f --top-module aluCoreTb \
	-Mdir "$buildDir" -o aluCoreTb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$buildDir/aluCoreTb" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the verdict
if grep -q "Errors found" "$logFile"; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation passed"
exit 0
